// ==== vlog.f ====
+incdir+src
src/simd_pkg.sv
src/simd_alu.sv
src/simd_half.sv
src/simd_unit.sv
bench/simd_tb.sv

// ==== Bender.yml ====
package:
  name: simd_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/simd_pkg.sv
      - src/simd_alu.sv
      - src/simd_half.sv
      - src/simd_unit.sv

  - target: test
    include_dirs:
      - src
    files:
      - bench/simd_tb.sv

// ==== bench/simd_tb.sv ====
// Self-checking testbench for simd_unit; compile it after the RTL and run simd_tb as the top
`timescale 1ns/1ps
`include "simd_config.svh"

module simd_tb
  import simd_pkg::*;
();

  localparam int W            = `SIMD_LANE_W;
  localparam int DEPTH        = `SIMD_PIPE_DEPTH;
  localparam int RESET_CYCLES = 2;
  localparam int N_DIRECTED   = 24;  // Directed vectors plus the reset and recovery ops
  localparam int N_BURST      = 120;
  localparam int N_GAPPED     = 40;  // Each one is followed by at most one idle cycle
  localparam int MAX_CYCLES   = 2 * RESET_CYCLES + N_DIRECTED + N_BURST + 2 * N_GAPPED
                                + 8 * (DEPTH + 1) + 40;

  logic                   clk;
  logic                   reset;
  logic                   in_valid;
  simd_op_e               op;
  logic [2*W-1:0]         a;
  logic [2*W-1:0]         b;
  logic                   res_valid;
  logic [2*W-1:0]         res;
  logic [`SIMD_RET_W-1:0] ret_code;

  int          cycle_count;
  logic [31:0] rng_state;
  string       test_name;

  // Outstanding operations in issue order
  logic [2*W-1:0]         exp_res_q[$];
  logic [`SIMD_RET_W-1:0] exp_ret_q[$];
  int                     exp_cycle_q[$];
  string                  name_q[$];

  simd_unit i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a),
    .b         (b),
    .res_valid (res_valid),
    .res       (res),
    .ret_code  (ret_code)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  // Expected {ret_code, res} for one full 64-bit operation
  function automatic logic [`SIMD_RET_W+2*W-1:0] ref_model(simd_op_e f_op,
                                                          logic [2*W-1:0] f_a,
                                                          logic [2*W-1:0] f_b);
    logic [W-1:0]           al;
    logic [W-1:0]           ah;
    logic [W-1:0]           bl;
    logic [W-1:0]           bh;
    logic [W-1:0]           rl;
    logic [W-1:0]           rh;
    logic                   cl;
    logic                   ch;
    logic [W:0]             wide;
    logic [`SIMD_RET_W-1:0] rc;
    al = f_a[W-1:0];
    ah = f_a[2*W-1:W];
    bl = f_b[W-1:0];
    bh = f_b[2*W-1:W];
    cl = 1'b0;
    ch = 1'b0;
    case (f_op)
      OP_ADD: begin
        wide = {1'b0, al} + {1'b0, bl};
        rl   = wide[W-1:0];
        cl   = wide[W];
        wide = {1'b0, ah} + {1'b0, bh};
        rh   = wide[W-1:0];
        ch   = wide[W];
      end
      OP_SUB: begin
        rl = al - bl;
        cl = (al < bl);  // Borrow whenever the subtrahend is larger
        rh = ah - bh;
        ch = (ah < bh);
      end
      OP_MAX: begin
        rl = (al > bl) ? al : bl;
        rh = (ah > bh) ? ah : bh;
      end
      OP_XOR: begin
        rl = al ^ bl;
        rh = ah ^ bh;
      end
      OP_SWAP: begin
        rl = ah;
        rh = al;
      end
      OP_HSUM: begin
        wide = {1'b0, al} + {1'b0, ah};
        rl   = wide[W-1:0];
        rh   = wide[W-1:0];
        cl   = wide[W];
        ch   = wide[W];
      end
      default: begin
        rl = '0;
        rh = '0;
      end
    endcase
    rc[RET_CARRY] = (f_op == OP_ADD || f_op == OP_SUB || f_op == OP_HSUM) && (cl || ch);
    rc[RET_ZERO]  = ({rh, rl} == '0);
    return {rc, rh, rl};
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Drives one operation and leaves the bench 2 ns after the edge that takes it
  task automatic issue(string name, simd_op_e o, logic [2*W-1:0] oa, logic [2*W-1:0] ob);
    test_name = name;
    in_valid  = 1'b1;
    op        = o;
    a         = oa;
    b         = ob;
    @(posedge clk);
    #2;
  endtask

  task automatic issue_random(string name);
    simd_op_e ro;
    logic [2*W-1:0] ra;
    logic [2*W-1:0] rb;
    ro = simd_op_e'(next_rand() % 6);
    ra = {next_rand(), next_rand()};
    rb = {next_rand(), next_rand()};
    issue(name, ro, ra, rb);
  endtask

  task automatic idle(int n);
    in_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      fail_run($sformatf("timeout: the run went past %0d cycles", MAX_CYCLES));
    end
  end

  // Outputs and the next issue are both stable at the falling edge
  always @(negedge clk) begin
    logic [`SIMD_RET_W+2*W-1:0] expected;
    string                      name;
    if (res_valid === 1'b1) begin
      if (exp_res_q.size() == 0) begin
        fail_run("res_valid went high with no operation outstanding");
      end else begin
        name = name_q.pop_front();
        check_value({name, " result"}, exp_res_q.pop_front(), res);
        check_value({name, " ret_code"}, exp_ret_q.pop_front(), ret_code);
        check_value({name, " latency"}, exp_cycle_q.pop_front(), cycle_count);
      end
    end
    if (reset) begin
      exp_res_q.delete();  // Everything in flight is dropped by the reset
      exp_ret_q.delete();
      exp_cycle_q.delete();
      name_q.delete();
    end else if (in_valid) begin
      expected = ref_model(op, a, b);
      exp_res_q.push_back(expected[2*W-1:0]);
      exp_ret_q.push_back(expected[`SIMD_RET_W+2*W-1:2*W]);
      exp_cycle_q.push_back(cycle_count + DEPTH);  // Taken at the next edge, out DEPTH edges on
      name_q.push_back(test_name);
    end
  end

  initial begin
    cycle_count = 0;
    rng_state   = 32'ha2fd;
    test_name   = "reset";
    reset       = 1'b1;
    in_valid    = 1'b0;
    op          = OP_ADD;
    a           = '0;
    b           = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;

    // Any res_valid here finds an empty queue
    test_name = "idle_after_reset";
    idle(5);

    issue("add_plain", OP_ADD, {32'd5, 32'd7}, {32'd10, 32'd20});
    issue("add_carry_hi", OP_ADD, {32'hffff_fff0, 32'd1}, {32'h0000_0020, 32'd2});
    issue("add_carry_lo", OP_ADD, {32'd1, 32'h8000_0001}, {32'd1, 32'h8000_0000});
    issue("sub_borrow_lo", OP_SUB, {32'd100, 32'd3}, {32'd40, 32'd9});
    issue("sub_plain", OP_SUB, {32'd100, 32'd90}, {32'd40, 32'd9});
    issue("max", OP_MAX, {32'h8000_0000, 32'd5}, {32'h7fff_ffff, 32'd9});
    issue("xor", OP_XOR, {32'hdead_beef, 32'h0f0f_0f0f}, {32'h1234_5678, 32'hffff_0000});
    idle(1);
    issue("swap", OP_SWAP, {32'h1234_5678, 32'h9abc_def0}, {32'hffff_ffff, 32'hffff_ffff});
    issue("hsum_carry", OP_HSUM, {32'hf000_0000, 32'h2000_0000}, 64'h0);
    issue("hsum_plain", OP_HSUM, {32'd1000, 32'd234}, {32'hffff_ffff, 32'd1});
    issue("xor_equal", OP_XOR, 64'h0123_4567_89ab_cdef, 64'h0123_4567_89ab_cdef);
    issue("sub_equal", OP_SUB, 64'h5555_aaaa_5555_aaaa, 64'h5555_aaaa_5555_aaaa);
    issue("add_wrap_zero", OP_ADD, 64'hffff_ffff_ffff_ffff, {32'd1, 32'd1});
    issue("xor_lo_zero", OP_XOR, {32'h0000_0001, 32'h4444_4444}, {32'h0, 32'h4444_4444});
    issue("swap_zero", OP_SWAP, 64'h0, 64'hffff_ffff_ffff_ffff);
    idle(DEPTH + 1);

    for (int i = 0; i < N_BURST; i++) begin
      issue_random("burst");
    end

    for (int i = 0; i < N_GAPPED; i++) begin
      issue_random("gapped");
      idle(next_rand() % 2);
    end
    idle(DEPTH + 1);

    // Reset rises as the first op reaches the output, so the two behind it must never appear
    issue_random("reset_flush");
    issue_random("reset_flush");
    issue_random("reset_flush");
    reset    = 1'b1;
    in_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset = 1'b0;
    check_value("reset_flush res_valid", 64'h0, res_valid);
    test_name = "after_flush";
    idle(DEPTH + 2);

    issue_random("recovery");
    issue_random("recovery");
    issue("recovery_hsum", OP_HSUM, {32'h7fff_ffff, 32'h8000_0001}, 64'h0);
    idle(DEPTH + 2);

    if (exp_res_q.size() != 0) begin
      fail_run($sformatf("%0d results were still outstanding at the end", exp_res_q.size()));
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

// ==== src/simd_unit.sv ====
// Top of the packed two-half SIMD unit with one issue port and a fixed-latency result port
`timescale 1ns/1ps
`include "simd_config.svh"

module simd_unit
  import simd_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       in_valid,
  input  simd_op_e                   op,
  input  logic [2*`SIMD_LANE_W-1:0]  a,
  input  logic [2*`SIMD_LANE_W-1:0]  b,
  output logic                       res_valid,
  output logic [2*`SIMD_LANE_W-1:0]  res,
  output logic [`SIMD_RET_W-1:0]     ret_code
);

  localparam int W     = `SIMD_LANE_W;
  localparam int DEPTH = `SIMD_PIPE_DEPTH;

  // Stage-1 A exchanged between the halves
  logic [W-1:0] lo_cross_a;
  logic [W-1:0] hi_cross_a;

  // Per-half status coming out of stage 3
  logic         lo_valid;
  logic         hi_valid;
  logic [W-1:0] lo_result;
  logic [W-1:0] hi_result;
  logic         lo_carry;
  logic         hi_carry;
  logic         lo_zero;
  logic         hi_zero;

  // The last entry of the opcode delay line lines up with the slice outputs
  simd_op_e     op_q [DEPTH];
  simd_op_e     ret_op;

  simd_half i_half_lo (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a[W-1:0]),
    .b         (b[W-1:0]),
    .peer_a    (hi_cross_a),
    .cross_a   (lo_cross_a),
    .out_valid (lo_valid),
    .result    (lo_result),
    .carry     (lo_carry),
    .half_zero (lo_zero)
  );

  simd_half i_half_hi (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .op        (op),
    .a         (a[2*W-1:W]),
    .b         (b[2*W-1:W]),
    .peer_a    (lo_cross_a),
    .cross_a   (hi_cross_a),
    .out_valid (hi_valid),
    .result    (hi_result),
    .carry     (hi_carry),
    .half_zero (hi_zero)
  );

  always_ff @(posedge clk) begin
    op_q[0] <= op;
    for (int i = 1; i < DEPTH; i++) begin
      op_q[i] <= op_q[i-1];
    end
  end

  assign ret_op = op_q[DEPTH-1];

  assign res_valid = lo_valid;  // Both halves run in lockstep
  assign res       = {hi_result, lo_result};

  // Carry only counts for the arithmetic ops
  assign ret_code[RET_CARRY] = op_has_carry(ret_op) & (lo_carry | hi_carry);
  assign ret_code[RET_ZERO]  = lo_zero & hi_zero;

  a_op_defined: assert property (
    @(posedge clk) disable iff (reset)
    in_valid |-> (op inside {OP_ADD, OP_SUB, OP_MAX, OP_XOR, OP_SWAP, OP_HSUM})
  ) else $error("simd_unit: undefined opcode issued");

  // A split here would mean the two slices saw different valids or resets
  a_halves_agree: assert property (
    @(posedge clk) disable iff (reset)
    lo_valid == hi_valid
  ) else $error("simd_unit: half slices disagree on out_valid");

  // Any reset inside the latency window disables the attempt
  a_fixed_latency: assert property (
    @(posedge clk) disable iff (reset)
    1'b1 |-> ##`SIMD_PIPE_DEPTH (res_valid == $past(in_valid, `SIMD_PIPE_DEPTH))
  ) else $error("simd_unit: res_valid does not follow in_valid by the pipeline depth");

endmodule

// ==== src/simd_half.sv ====
// One 32-bit half slice of the SIMD unit with its three-stage pipeline, used twice by the top
`timescale 1ns/1ps
`include "simd_config.svh"

module simd_half
  import simd_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_valid,
  input  simd_op_e                 op,
  input  logic [`SIMD_LANE_W-1:0]  a,
  input  logic [`SIMD_LANE_W-1:0]  b,
  input  logic [`SIMD_LANE_W-1:0]  peer_a,     // Stage-1 A of the other half
  output logic [`SIMD_LANE_W-1:0]  cross_a,    // Stage-1 A offered to the other half
  output logic                     out_valid,
  output logic [`SIMD_LANE_W-1:0]  result,
  output logic                     carry,
  output logic                     half_zero
);

  localparam int W     = `SIMD_LANE_W;
  localparam int DEPTH = `SIMD_PIPE_DEPTH;

  // Valid travels down a shift chain, one bit per register stage
  logic [DEPTH-1:0] valid_q;

  // Stage 1 holds the issued operands and op
  simd_op_e         s1_op;
  logic [W-1:0]     s1_a;
  logic [W-1:0]     s1_b;

  // Stage 2 holds the raw ALU output
  logic [W-1:0]     alu_result;
  logic             alu_carry;
  logic [W-1:0]     s2_result;
  logic             s2_carry;

  // Stage 3 is the output register
  logic [W-1:0]     s3_result;
  logic             s3_carry;
  logic             s3_zero;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[DEPTH-2:0], in_valid};
    end
  end

  always_ff @(posedge clk) begin
    s1_op <= op;
    s1_a  <= a;
    s1_b  <= b;
  end

  // The neighbor sees this A in the same cycle as our own ALU does
  assign cross_a = s1_a;

  simd_alu i_alu (
    .op     (s1_op),
    .a      (s1_a),
    .b      (s1_b),
    .peer_a (peer_a),
    .result (alu_result),
    .carry  (alu_carry)
  );

  always_ff @(posedge clk) begin
    s2_result <= alu_result;
    s2_carry  <= alu_carry;
  end

  // Zero detect sits in the last stage so the ALU path stays short
  always_ff @(posedge clk) begin
    s3_result <= s2_result;
    s3_carry  <= s2_carry;
    s3_zero   <= (s2_result == '0);
  end

  assign out_valid = valid_q[DEPTH-1];
  assign result    = s3_result;
  assign carry     = s3_carry;
  assign half_zero = s3_zero;

  // A valid beat must carry a known value, which catches a missing peer hookup
  a_result_known: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |-> !$isunknown(result)
  ) else $error("simd_half: unknown result while out_valid is high");

endmodule

// ==== src/simd_alu.sv ====
// Combinational arithmetic for one lane half, instantiated once per slice
`timescale 1ns/1ps
`include "simd_config.svh"

module simd_alu
  import simd_pkg::*;
(
  input  simd_op_e                 op,
  input  logic [`SIMD_LANE_W-1:0]  a,
  input  logic [`SIMD_LANE_W-1:0]  b,
  input  logic [`SIMD_LANE_W-1:0]  peer_a,
  output logic [`SIMD_LANE_W-1:0]  result,
  output logic                     carry
);

  localparam int W = `SIMD_LANE_W;

  // One bit wider than the lane so the top bit is the carry or borrow
  logic [W:0] sum_ab;
  logic [W:0] diff_ab;
  logic [W:0] sum_peer;
  logic       a_ge_b;

  assign sum_ab   = {1'b0, a} + {1'b0, b};
  assign diff_ab  = {1'b0, a} - {1'b0, b};  // Bit W set means a borrow occurred
  assign sum_peer = {1'b0, a} + {1'b0, peer_a};
  assign a_ge_b   = (a >= b);  // Unsigned compare

  always_comb begin
    result = '0;
    carry  = 1'b0;
    case (op)
      OP_ADD: begin
        result = sum_ab[W-1:0];
        carry  = sum_ab[W];
      end
      OP_SUB: begin
        result = diff_ab[W-1:0];
        carry  = diff_ab[W];
      end
      OP_MAX: begin
        result = a_ge_b ? a : b;
      end
      OP_XOR: begin
        result = a ^ b;
      end
      OP_SWAP: begin
        result = peer_a;  // The neighbor's A lands in this half
      end
      OP_HSUM: begin
        // Both halves compute the same sum, so the two results always match
        result = sum_peer[W-1:0];
        carry  = sum_peer[W];
      end
      default: begin
        result = '0;
        carry  = 1'b0;
      end
    endcase
  end

endmodule

// ==== src/simd_pkg.sv ====
// Opcode type and return-code layout shared by the SIMD RTL and its testbench
package simd_pkg;

  // Lane operations, 3-bit encoding
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,  // Wrapping add per half
    OP_SUB  = 3'd1,  // Wrapping subtract per half
    OP_MAX  = 3'd2,  // Unsigned maximum per half
    OP_XOR  = 3'd3,  // Bitwise exclusive or
    OP_SWAP = 3'd4,  // Exchange the A halves
    OP_HSUM = 3'd5   // Low A plus high A into both halves
  } simd_op_e;

  // Bit positions inside ret_code
  localparam int RET_CARRY = 0;  // Carry or borrow out of any half
  localparam int RET_ZERO  = 1;  // Whole 64-bit result is zero

  // Only the arithmetic ops report a carry, everything else forces it low
  function automatic logic op_has_carry(simd_op_e op);
    logic has_carry;
    case (op)
      OP_ADD, OP_SUB, OP_HSUM: has_carry = 1'b1;
      default:                 has_carry = 1'b0;
    endcase
    return has_carry;
  endfunction

endpackage

// ==== src/simd_config.svh ====
// Build-time sizes for the packed SIMD unit, included by every RTL file and the testbench
`ifndef SIMD_CONFIG_SVH
`define SIMD_CONFIG_SVH

// Width of one lane half, so the full operand is twice this
`define SIMD_LANE_W 32

// Register stages from the issue port to the result port
`define SIMD_PIPE_DEPTH 3

// Width of the merged return code
`define SIMD_RET_W 2

`endif
